// File: Makefile
TOP := rf_fifo_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module rf_fifo_top -f rf_fifo.f
	verilator --lint-only --timing --top-module $(TOP) -f rf_fifo.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rf_fifo.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "Result: FAIL"; exit 1; \
	elif grep -q "Simulation completed successfully" sim.log; then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL, the run ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: rf_fifo.f
src/rf_pkg.sv
src/pwr_pkg.sv
src/mem_reset_sync.sv
src/rf_array_32x10.sv
src/rf_pg_32x10.sv
src/rf_pwr_ctl.sv
src/rf_fifo_ctl.sv
src/rf_fifo_top.sv
verification/rf_fifo_tb.sv

// File: src/mem_reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

module mem_reset_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic fscan_rstbypen,
    input  logic fscan_byprst_b,
    output logic rst_n_sync
);

    // Two-stage shift of a constant one
    // Assertion is immediate through the async clear, release takes two edges
    logic [1:0] sync_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // In scan the tester owns the reset directly and the flops are skipped
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[1];

endmodule

`default_nettype wire

// File: src/pwr_pkg.sv
`default_nettype none

// Power sequencing definitions for the gated register file
package pwr_pkg;

    // Sleep goes AWAKE, ISOLATING, POWER_DOWN, ASLEEP
    // Wake goes ASLEEP, POWER_UP, AWAKE with isolation held inside POWER_UP
    typedef enum logic [2:0] {
        PWR_AWAKE      = 3'd0,
        PWR_ISOLATING  = 3'd1,
        PWR_POWER_DOWN = 3'd2,
        PWR_ASLEEP     = 3'd3,
        PWR_POWER_UP   = 3'd4
    } pwr_state_t;

    // Controls sent to the array
    // pwr_enable_b is active low, so a high level means the array is off
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
    } pwr_ctl_t;

endpackage

`default_nettype wire

// File: src/rf_array_32x10.sv
`timescale 1ns/1ps
`default_nettype none

module rf_array_32x10 #(
    parameter int CHAIN_DELAY = 3
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rf_pkg::rf_wr_t            wr,
    input  rf_pkg::rf_rd_t            rd,
    input  logic                      isol_en,
    input  logic                      pwr_enable_b_in,
    output logic                      pwr_enable_b_out,
    output logic [rf_pkg::DATA_W-1:0] rdata
);

    logic [rf_pkg::DATA_W-1:0] mem [rf_pkg::DEPTH];
    logic [rf_pkg::DATA_W-1:0] rdata_q;
    logic [CHAIN_DELAY-1:0]    chain_q;

    // ------------------------------------------------------------------------
    // Power-enable daisy chain
    // ------------------------------------------------------------------------

    // Models the switch chain running through the macro
    // The echo at the far end tells the sequencer the rail has settled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chain_q <= '0;
        end else begin
            chain_q[0] <= pwr_enable_b_in;
            for (int i = 1; i < CHAIN_DELAY; i++) begin
                chain_q[i] <= chain_q[i-1];
            end
        end
    end

    assign pwr_enable_b_out = chain_q[CHAIN_DELAY-1];

    // ------------------------------------------------------------------------
    // Storage and read register
    // ------------------------------------------------------------------------

    // Once the rail is down every cell is lost
    always_ff @(posedge clk) begin
        if (pwr_enable_b_out) begin
            for (int i = 0; i < rf_pkg::DEPTH; i++) begin
                mem[i] <= 'x;
            end
        end else if (wr.we) begin
            mem[wr.waddr] <= wr.wdata;
        end
    end

    // Read data is flopped, so it shows up one edge after re
    always_ff @(posedge clk) begin
        if (rd.re) begin
            rdata_q <= mem[rd.raddr];
        end
    end

    // Clamp keeps a floating output from reaching the logic that stays powered
    assign rdata = isol_en ? '0 : rdata_q;

    // No access may reach a powered-down array
    a_no_access_off : assert property (@(posedge clk) disable iff (!rst_n)
        (wr.we || rd.re) |-> !pwr_enable_b_out);

    // The rail may only be off, or going off, behind the clamp
    a_pwr_down_isol : assert property (@(posedge clk) disable iff (!rst_n)
        (pwr_enable_b_in || pwr_enable_b_out) |-> isol_en);

endmodule

`default_nettype wire

// File: src/rf_fifo_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module rf_fifo_ctl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  logic [rf_pkg::DATA_W-1:0] push_data,
    input  logic                      pop,
    input  logic                      awake,
    output rf_pkg::rf_wr_t            wr,
    output rf_pkg::rf_rd_t            rd,
    output rf_pkg::fifo_stat_t        stat,
    output logic                      pop_valid
);

    localparam int CNT_W = rf_pkg::ADDR_W + 1;
    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(rf_pkg::DEPTH);

    logic [rf_pkg::ADDR_W-1:0] wptr_q;
    logic [rf_pkg::ADDR_W-1:0] rptr_q;
    logic [CNT_W-1:0]          count_q;
    logic                      empty;
    logic                      full;
    logic                      do_push;
    logic                      do_pop;

    assign empty = (count_q == '0);
    assign full  = (count_q == DEPTH_C);

    // Strobes that fail these checks are simply lost
    assign do_push = push && awake && !full;
    assign do_pop  = pop && awake && !empty;

    // ------------------------------------------------------------------------
    // Array access
    // ------------------------------------------------------------------------

    assign wr.we    = do_push;
    assign wr.waddr = wptr_q;
    assign wr.wdata = push_data;

    // Read data comes back from the array flop one edge later
    assign rd.re    = do_pop;
    assign rd.raddr = rptr_q;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr_q    <= '0;
            rptr_q    <= '0;
            count_q   <= '0;
            pop_valid <= 1'b0;
        end else begin
            // Pointers wrap at DEPTH on their own
            if (do_push) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (do_pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
            // Push and pop in the same cycle cancel out
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Lines up with the registered array read
            pop_valid <= do_pop;
        end
    end

    assign stat.empty = empty;
    assign stat.full  = full;
    assign stat.count = count_q;

    a_count_bound : assert property (@(posedge clk) disable iff (!rst_n)
        count_q <= DEPTH_C);

endmodule

`default_nettype wire

// File: src/rf_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module rf_fifo_top #(
    parameter int CHAIN_DELAY = 3,
    parameter int ISOL_CYCLES = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  logic [rf_pkg::DATA_W-1:0] push_data,
    input  logic                      pop,
    input  logic                      sleep_req,
    input  logic                      fscan_rstbypen,
    input  logic                      fscan_byprst_b,
    output logic                      pop_valid,
    output logic [rf_pkg::DATA_W-1:0] pop_data,
    output rf_pkg::fifo_stat_t        stat,
    output logic                      awake
);

    rf_pkg::rf_wr_t    wr;
    rf_pkg::rf_rd_t    rd;
    pwr_pkg::pwr_ctl_t pwr_ctl;
    logic              pwr_enable_b_out;

    rf_fifo_ctl i_fifo_ctl (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .awake     (awake),
        .wr        (wr),
        .rd        (rd),
        .stat      (stat),
        .pop_valid (pop_valid)
    );

    // Sleep is only entered once the FIFO has drained
    rf_pwr_ctl #(
        .ISOL_CYCLES (ISOL_CYCLES)
    ) i_pwr_ctl (
        .clk              (clk),
        .rst_n            (rst_n),
        .sleep_req        (sleep_req),
        .fifo_empty       (stat.empty),
        .pwr_enable_b_out (pwr_enable_b_out),
        .ctl              (pwr_ctl),
        .awake            (awake)
    );

    // Single clock domain, so one clock feeds both ports
    rf_pg_32x10 #(
        .CHAIN_DELAY (CHAIN_DELAY)
    ) i_rf_pg (
        .wclk             (clk),
        .rclk             (clk),
        .rst_n            (rst_n),
        .wr               (wr),
        .rd               (rd),
        .rdata            (pop_data),
        .pgcb_isol_en     (pwr_ctl.isol_en),
        .pwr_enable_b_in  (pwr_ctl.pwr_enable_b),
        .pwr_enable_b_out (pwr_enable_b_out),
        .fscan_rstbypen   (fscan_rstbypen),
        .fscan_byprst_b   (fscan_byprst_b)
    );

endmodule

`default_nettype wire

// File: src/rf_pg_32x10.sv
`timescale 1ns/1ps
`default_nettype none

module rf_pg_32x10 #(
    parameter int CHAIN_DELAY = 3
) (
    input  logic                      wclk,
    input  logic                      rclk,
    input  logic                      rst_n,
    input  rf_pkg::rf_wr_t            wr,
    input  rf_pkg::rf_rd_t            rd,
    output logic [rf_pkg::DATA_W-1:0] rdata,

    // Power interface
    input  logic                      pgcb_isol_en,
    input  logic                      pwr_enable_b_in,
    output logic                      pwr_enable_b_out,

    // Scan reset control
    input  logic                      fscan_rstbypen,
    input  logic                      fscan_byprst_b
);

    logic rst_n_sync;

    // Array reset is released synchronously to the read clock
    mem_reset_sync i_rst_sync (
        .clk            (rclk),
        .rst_n          (rst_n),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst_b (fscan_byprst_b),
        .rst_n_sync     (rst_n_sync)
    );

    // ------------------------------------------------------------------------
    // Storage array
    // ------------------------------------------------------------------------

    // Both ports share one domain here, the array runs on the write clock
    rf_array_32x10 #(
        .CHAIN_DELAY (CHAIN_DELAY)
    ) i_rf (
        .clk              (wclk),
        .rst_n            (rst_n_sync),
        .wr               (wr),
        .rd               (rd),
        .isol_en          (pgcb_isol_en),
        .pwr_enable_b_in  (pwr_enable_b_in),
        .pwr_enable_b_out (pwr_enable_b_out),
        .rdata            (rdata)
    );

endmodule

`default_nettype wire

// File: src/rf_pkg.sv
`default_nettype none

// Geometry and bundles shared by the register file, its wrapper and the FIFO
package rf_pkg;

    // ------------------------------------------------------------------------
    // Array geometry
    // ------------------------------------------------------------------------

    // Five address bits cover exactly the 32 entries, so pointers wrap by themselves
    localparam int ADDR_W = 5;
    localparam int DATA_W = 10;
    localparam int DEPTH  = 32;

    // Write port of the two-port array
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] waddr;
        logic [DATA_W-1:0] wdata;
    } rf_wr_t;

    // Read port of the two-port array
    typedef struct packed {
        logic              re;
        logic [ADDR_W-1:0] raddr;
    } rf_rd_t;

    // Occupancy seen from outside
    // The count carries one extra bit so that a full FIFO of DEPTH words fits
    typedef struct packed {
        logic            empty;
        logic            full;
        logic [ADDR_W:0] count;
    } fifo_stat_t;

endpackage

`default_nettype wire

// File: src/rf_pwr_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module rf_pwr_ctl #(
    parameter int ISOL_CYCLES = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sleep_req,
    input  logic              fifo_empty,
    input  logic              pwr_enable_b_out,
    output pwr_pkg::pwr_ctl_t ctl,
    output logic              awake
);

    localparam int CNT_W = (ISOL_CYCLES > 1) ? $clog2(ISOL_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(ISOL_CYCLES - 1);

    pwr_pkg::pwr_state_t state_q;
    pwr_pkg::pwr_state_t state_nxt;
    logic [CNT_W-1:0]    isol_cnt_q;
    logic                cnt_done;

    assign cnt_done = (isol_cnt_q == CNT_LAST);

    // ------------------------------------------------------------------------
    // Sequencer FSM
    // ------------------------------------------------------------------------

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            pwr_pkg::PWR_AWAKE: begin
                if (sleep_req && fifo_empty) begin
                    state_nxt = pwr_pkg::PWR_ISOLATING;
                end
            end
            // A push taken on the last awake edge makes the FIFO non-empty
            // Backing out here is safe since the rail is still up
            pwr_pkg::PWR_ISOLATING: begin
                if (!sleep_req || !fifo_empty) begin
                    state_nxt = pwr_pkg::PWR_AWAKE;
                end else if (cnt_done) begin
                    state_nxt = pwr_pkg::PWR_POWER_DOWN;
                end
            end
            // Wait for the chain to echo the off level
            pwr_pkg::PWR_POWER_DOWN: begin
                if (pwr_enable_b_out) begin
                    state_nxt = pwr_pkg::PWR_ASLEEP;
                end
            end
            pwr_pkg::PWR_ASLEEP: begin
                if (!sleep_req) begin
                    state_nxt = pwr_pkg::PWR_POWER_UP;
                end
            end
            // Echo first, then the isolation hold before the clamp opens
            pwr_pkg::PWR_POWER_UP: begin
                if (!pwr_enable_b_out && cnt_done) begin
                    state_nxt = pwr_pkg::PWR_AWAKE;
                end
            end
            default: begin
                state_nxt = pwr_pkg::PWR_AWAKE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= pwr_pkg::PWR_AWAKE;
        end else begin
            state_q <= state_nxt;
        end
    end

    // Counter restarts on every state change
    // In POWER_UP it only runs once the chain reports the rail is back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isol_cnt_q <= '0;
        end else if (state_nxt != state_q) begin
            isol_cnt_q <= '0;
        end else if (state_q == pwr_pkg::PWR_ISOLATING ||
                     (state_q == pwr_pkg::PWR_POWER_UP && !pwr_enable_b_out)) begin
            isol_cnt_q <= isol_cnt_q + 1'b1;
        end
    end

    // Outputs are decoded from the state register
    assign awake            = (state_q == pwr_pkg::PWR_AWAKE);
    assign ctl.isol_en      = (state_q != pwr_pkg::PWR_AWAKE);
    assign ctl.pwr_enable_b = (state_q == pwr_pkg::PWR_POWER_DOWN) ||
                              (state_q == pwr_pkg::PWR_ASLEEP);

    // The rail only goes down once isolation has been held for ISOL_CYCLES
    a_pwr_off_isol : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ctl.pwr_enable_b) |-> $past(ctl.isol_en, ISOL_CYCLES));

endmodule

`default_nettype wire

// File: verification/rf_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rf_fifo_tb;

    localparam int MAX_LINES = 64;

    logic                      clk;
    logic                      rst_n;
    logic                      push;
    logic [rf_pkg::DATA_W-1:0] push_data;
    logic                      pop;
    logic                      sleep_req;
    logic                      fscan_rstbypen;
    logic                      fscan_byprst_b;
    logic                      pop_valid;
    logic [rf_pkg::DATA_W-1:0] pop_data;
    rf_pkg::fifo_stat_t        stat;
    logic                      awake;

    // Each trace line holds four words in the order op, data, check kind and expected value
    logic [31:0]               trace_mem [4*MAX_LINES];
    int                        n_lines      = 0;
    int                        cycle_cnt    = 0;
    int                        cycle_limit  = 0;
    int                        check_errors = 0;
    int                        tests_run    = 0;
    int                        tests_failed = 0;
    logic [31:0]               rng_state    = 32'hef1e;

    // Reference FIFO that follows the acceptance rules for push and pop
    logic [rf_pkg::DATA_W-1:0] model_q [$];
    bit                        model_asleep = 1'b0;

    rf_fifo_top #(
        .CHAIN_DELAY (3),
        .ISOL_CYCLES (2)
    ) rf_fifo_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (push),
        .push_data      (push_data),
        .pop            (pop),
        .sleep_req      (sleep_req),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst_b (fscan_byprst_b),
        .pop_valid      (pop_valid),
        .pop_data       (pop_data),
        .stat           (stat),
        .awake          (awake)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // The watchdog limit is set once the trace length is known
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run hung after %0d cycles without finishing the trace",
                     cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------------------------------------------------------------
    // Helpers
    // --------------------------------------------------------------------------

    // Inputs change and outputs are sampled 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            check_errors++;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string op_name(input logic [31:0] op);
        case (op)
            32'h0:   return "wait";
            32'h1:   return "push";
            32'h2:   return "pop";
            32'h3:   return "sleep";
            32'h4:   return "wake";
            32'h5:   return "fill";
            32'h6:   return "drain";
            32'h7:   return "pushpop";
            default: return "unknown";
        endcase
    endfunction

    // One push strobe that the model takes only when the DUT is meant to
    task automatic push_cycle(input logic [rf_pkg::DATA_W-1:0] word);
        bit push_ok;
        push_ok   = !model_asleep && model_q.size() < rf_pkg::DEPTH;
        push      = 1'b1;
        push_data = word;
        step();
        push = 1'b0;
        if (push_ok) begin
            model_q.push_back(word);
        end
    endtask

    // One pop strobe, optionally with a push in the same cycle
    // Both acceptance decisions use the occupancy before the edge
    task automatic pop_cycle(input string name, input bit with_push,
                             input logic [rf_pkg::DATA_W-1:0] word);
        bit                        pop_ok;
        bit                        push_ok;
        logic [rf_pkg::DATA_W-1:0] front;
        pop_ok    = !model_asleep && model_q.size() > 0;
        push_ok   = with_push && !model_asleep && model_q.size() < rf_pkg::DEPTH;
        front     = pop_ok ? model_q[0] : '0;
        pop       = 1'b1;
        push      = with_push;
        push_data = word;
        step();
        pop  = 1'b0;
        push = 1'b0;
        if (pop_ok) begin
            void'(model_q.pop_front());
        end
        if (push_ok) begin
            model_q.push_back(word);
        end
        compare({name, "_valid"}, 32'(pop_ok), 32'(pop_valid));
        if (pop_ok) begin
            compare({name, "_data"}, 32'(front), 32'(pop_data));
        end
    endtask

    // An empty FIFO must go to sleep and a filled one must stay awake
    task automatic enter_sleep(input string name, input logic [31:0] cycles);
        sleep_req = 1'b1;
        if (model_q.size() == 0) begin
            model_asleep = 1'b1;
            while (awake) begin
                step();
            end
            repeat (cycles) step();
        end else begin
            repeat (cycles) begin
                step();
                compare({name, "_awake"}, 32'd1, 32'(awake));
            end
        end
    endtask

    // Once the wake sequence ends awake has to hold past the next edge
    task automatic leave_sleep();
        sleep_req = 1'b0;
        while (!awake) begin
            step();
        end
        model_asleep = 1'b0;
        step();
    endtask

    task automatic run_op(input string name, input logic [31:0] op, input logic [31:0] arg);
        case (op)
            32'h0: repeat (arg) step();
            32'h1: push_cycle(arg[rf_pkg::DATA_W-1:0]);
            32'h2: pop_cycle(name, 1'b0, '0);
            32'h3: enter_sleep(name, arg);
            32'h4: leave_sleep();
            32'h5: begin
                // Fill words are random
                repeat (arg) begin
                    rng_state = xorshift(rng_state);
                    push_cycle(rng_state[rf_pkg::DATA_W-1:0]);
                end
            end
            32'h6: repeat (arg) pop_cycle(name, 1'b0, '0);
            32'h7: pop_cycle(name, 1'b1, arg[rf_pkg::DATA_W-1:0]);
            default: begin
                check_errors++;
                $display("Trace line %s holds an operation code that is not known: %0h",
                         name, op);
            end
        endcase
    endtask

    // --------------------------------------------------------------------------
    // Trace sequencing
    // --------------------------------------------------------------------------

    initial begin
        int          errs_at_start;
        string       name;
        logic [31:0] op;
        logic [31:0] arg;
        logic [31:0] chk;
        logic [31:0] exp_val;

        rst_n          = 1'b0;
        push           = 1'b0;
        push_data      = '0;
        pop            = 1'b0;
        sleep_req      = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        errs_at_start  = 0;

        $readmemh("verification/rf_fifo_trace.txt", trace_mem);
        while (n_lines < MAX_LINES && !$isunknown(trace_mem[4*n_lines])) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            check_errors++;
            $display("No operations could be read from the trace file");
        end
        cycle_limit = n_lines * 40;

        repeat (4) step();
        rst_n = 1'b1;

        for (int ln = 0; ln < n_lines; ln++) begin
            op      = trace_mem[4*ln];
            arg     = trace_mem[4*ln+1];
            chk     = trace_mem[4*ln+2];
            exp_val = trace_mem[4*ln+3];
            name    = $sformatf("%s_%0d", op_name(op), ln);
            run_op(name, op, arg);
            // A line with a check kind closes one test
            if (chk != 32'd0) begin
                case (chk)
                    32'd1:   compare({name, "_pop_data"}, exp_val, 32'(pop_data));
                    32'd2:   compare({name, "_stat"}, exp_val, 32'(stat));
                    32'd3:   compare({name, "_awake"}, exp_val, 32'(awake));
                    default: begin
                        check_errors++;
                        $display("Trace line %s asks for a check kind that is not known", name);
                    end
                endcase
                tests_run++;
                if (check_errors != errs_at_start) begin
                    tests_failed++;
                    $display("[FAIL] %s", name);
                end else begin
                    $display("[PASS] %s", name);
                end
                errs_at_start = check_errors;
            end
        end

        $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, check_errors);
        if (check_errors == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/rf_fifo_trace.txt
// Columns: op data check expected, all hex
// op 0 wait 1 push 2 pop 3 sleep 4 wake 5 fill 6 drain 7 pushpop; check 1 pop data 2 stat 3 awake
0 001 2 080  // Empty after reset
1 155 0 000  // Words leave in the order they went in
1 2aa 0 000
1 07c 2 003
2 000 1 155
2 000 1 2aa
2 000 1 07c
0 001 2 080
5 020 2 060  // 32 random words set full
1 3ff 2 060  // The 33rd push is dropped
2 000 1 00f  // First xorshift word from seed ef1e
6 01f 2 080  // The other 31 drain back to empty
2 000 2 080  // Pop on empty is ignored
1 123 2 001
7 234 2 001  // Push and pop together keep the count
2 000 1 234
0 001 2 080
3 008 3 000  // Sleep on empty lowers awake
1 0aa 2 080  // Push while asleep is dropped
4 000 3 001  // Awake returns once the request drops
1 1c3 2 001
2 000 1 1c3
1 0f0 0 000  // Sleep with data held stays awake
1 30f 2 002
3 008 3 001
4 000 3 001
2 000 1 0f0
2 000 1 30f
0 001 2 080
